//--- hdl/fetch_pkg.sv
// fetch front end shared types
package fetch_pkg;

	localparam int xlen = 32; // address and instruction width

	////////////////////////////////////////////////////////////
	// bus command and opcode encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		bus_none = 2'h0, // idle cycle
		bus_load = 2'h1  // combinational read of one 64-bit word
	} bus_command_t;

	localparam logic [6:0] op_alu_reg = 7'b0110011;
	localparam logic [6:0] op_alu_imm = 7'b0010011;
	localparam logic [6:0] op_load    = 7'b0000011;
	localparam logic [6:0] op_store   = 7'b0100011;
	localparam logic [6:0] op_branch  = 7'b1100011;
	localparam logic [6:0] op_jal     = 7'b1101111;

	typedef enum logic [2:0] {
		cls_alu_reg,
		cls_alu_imm,
		cls_load,
		cls_store,
		cls_branch,
		cls_jal,
		cls_other // jalr, lui, auipc, system all land here
	} inst_class_t;

	////////////////////////////////////////////////////////////
	// instruction word layouts
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [6:0] funct7; // also the upper s/b immediate bits
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;     // also the lower s/b immediate bits
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// jump immediate is scattered across the upper 20 bits
	typedef struct packed {
		logic       imm_20;    // sign
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} inst_word_t;

	////////////////////////////////////////////////////////////
	// stage packets
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;  // pc + 4
		inst_word_t      inst;
	} if_id_packet_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		inst_class_t     inst_class;
		logic [4:0]      rd;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [xlen-1:0] imm; // sign extended
	} id_packet_t;

endpackage

//--- hdl/fetch_if.sv
// fetch to decode link
interface fetch_if import fetch_pkg::*; ();

	logic            valid; // one instruction this cycle, no handshake
	logic [xlen-1:0] pc;    // address of inst
	logic [xlen-1:0] npc;   // sequential successor
	inst_word_t      inst;  // selected 32-bit half

	// fetch side
	modport source (
		output valid,
		output pc,
		output npc,
		output inst
	);

	// decode side
	modport sink (
		input valid,
		input pc,
		input npc,
		input inst
	);

endinterface

//--- hdl/imem_bank.sv
// instruction memory bank
module imem_bank import fetch_pkg::*; #(
	parameter int imem_words = 256 // depth in 64-bit words, power of two
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          write_en,
	input  logic [$clog2(imem_words)-1:0] write_addr, // word index
	input  logic [63:0]                   write_data,
	input  logic [xlen-1:0]               proc2imem_addr,    // byte address
	input  bus_command_t                  proc2imem_command,
	output logic [63:0]                   imem2proc_data,
	output logic [3:0]                    imem2proc_response,
	output logic [3:0]                    imem2proc_tag
);

	localparam int index_bits = $clog2(imem_words);

	logic [63:0]           mem [imem_words]; // image storage, no reset
	logic [index_bits-1:0] read_index;
	logic [3:0]            tag_count;        // last tag handed out
	logic [3:0]            tag_next;
	logic                  load;

	// byte address to word index, low three bits pick the byte inside the word
	assign read_index = proc2imem_addr[3 +: index_bits];
	assign load       = (proc2imem_command == bus_load);

	// write port, takes effect at the edge
	always_ff @(posedge clock) begin
		if (write_en) begin
			mem[write_addr] <= write_data;
		end
	end

	assign imem2proc_data = mem[read_index]; // same-cycle read

	////////////////////////////////////////////////////////////
	// response tag, walks 1..15 and never hits zero
	////////////////////////////////////////////////////////////

	assign tag_next = (tag_count == 4'hf) ? 4'h1 : tag_count + 4'h1;

	always_ff @(posedge clock) begin
		if (reset) begin
			tag_count <= 4'h0;
		end else if (load) begin
			tag_count <= tag_next; // advance only when a tag was used
		end
	end

	assign imem2proc_tag      = load ? tag_next : 4'h0;
	assign imem2proc_response = imem2proc_tag; // read always accepted

endmodule

//--- hdl/if_stage.sv
// instruction fetch stage
module if_stage import fetch_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic            if_enable,      // fetch this cycle
	input  logic            ex_take_branch, // outside redirect
	input  logic [xlen-1:0] ex_target_pc,
	input  logic            jal_take,       // from decode, same cycle
	input  logic [xlen-1:0] jal_target,
	input  logic [63:0]     imem2proc_data,
	input  logic [3:0]      imem2proc_response,
	input  logic [3:0]      imem2proc_tag,
	output logic [xlen-1:0] proc2imem_addr,
	output bus_command_t    proc2imem_command,
	fetch_if.source         if_out
);

	logic [xlen-1:0] pc_reg;    // pc being fetched now
	logic [xlen-1:0] pc_plus_4;
	logic [xlen-1:0] next_pc;
	logic            pc_enable;
	if_id_packet_t   fetch_pkt;

	// memory is 64 bits wide so drop the word offset
	assign proc2imem_addr    = {pc_reg[xlen-1:3], 3'b000};
	assign proc2imem_command = if_enable ? bus_load : bus_none;

	assign pc_plus_4 = pc_reg + xlen'(4);

	// outside redirect beats the jal, jal beats sequential
	assign next_pc = ex_take_branch ? ex_target_pc :
	                 jal_take       ? jal_target   :
	                                  pc_plus_4;

	// tag left out here since it depends on the command in the same cycle
	assign pc_enable = if_enable | ex_take_branch;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= '0; // start at address zero
		end else if (pc_enable) begin
			pc_reg <= next_pc;
		end
	end

	////////////////////////////////////////////////////////////
	// packet toward decode
	////////////////////////////////////////////////////////////

	// a live tag that matches the response marks the data as ours
	assign fetch_pkt.valid = (imem2proc_tag != 4'h0) && (imem2proc_response == imem2proc_tag);
	assign fetch_pkt.pc    = pc_reg;
	assign fetch_pkt.npc   = pc_plus_4;
	assign fetch_pkt.inst  = pc_reg[2] ? imem2proc_data[63:32] : imem2proc_data[31:0]; // half select

	assign if_out.valid = fetch_pkt.valid;
	assign if_out.pc    = fetch_pkt.pc;
	assign if_out.npc   = fetch_pkt.npc;
	assign if_out.inst  = fetch_pkt.inst;

endmodule

//--- hdl/inst_decode.sv
// instruction decode
module inst_decode import fetch_pkg::*; (
	fetch_if.sink           if_in,
	output id_packet_t      id_out,
	output logic            jal_take,   // steer fetch this cycle
	output logic [xlen-1:0] jal_target
);

	inst_word_t      inst;
	logic [6:0]      opcode;
	inst_class_t     inst_class;
	logic [xlen-1:0] i_imm;
	logic [xlen-1:0] s_imm;
	logic [xlen-1:0] b_imm;
	logic [xlen-1:0] j_imm;
	logic [xlen-1:0] imm;

	assign inst   = if_in.inst;
	assign opcode = inst.r_fmt.opcode; // same bits in every view

	////////////////////////////////////////////////////////////
	// opcode class
	////////////////////////////////////////////////////////////

	always_comb begin
		case (opcode)
			op_alu_reg: inst_class = cls_alu_reg;
			op_alu_imm: inst_class = cls_alu_imm;
			op_load:    inst_class = cls_load;
			op_store:   inst_class = cls_store;
			op_branch:  inst_class = cls_branch;
			op_jal:     inst_class = cls_jal;
			default:    inst_class = cls_other;
		endcase
	end

	////////////////////////////////////////////////////////////
	// immediates, all sign extended from the top bit
	////////////////////////////////////////////////////////////

	assign i_imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};

	// store and branch reuse the funct7 and rd slots of the register layout
	assign s_imm = {{20{inst.r_fmt.funct7[6]}}, inst.r_fmt.funct7, inst.r_fmt.rd};
	assign b_imm = {{20{inst.r_fmt.funct7[6]}}, inst.r_fmt.rd[0],
	                inst.r_fmt.funct7[5:0], inst.r_fmt.rd[4:1], 1'b0};

	assign j_imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
	                inst.j_fmt.imm_10_1, 1'b0};

	always_comb begin
		case (inst_class)
			cls_alu_imm,
			cls_load:   imm = i_imm;
			cls_store:  imm = s_imm;
			cls_branch: imm = b_imm;
			cls_jal:    imm = j_imm;
			default:    imm = '0; // register ops and the rest carry none
		endcase
	end

	////////////////////////////////////////////////////////////
	// jal redirect
	////////////////////////////////////////////////////////////

	assign jal_target = if_in.pc + j_imm;

	// a jump to the next word needs no steering
	assign jal_take = if_in.valid && (inst_class == cls_jal) && (jal_target != if_in.npc);

	// packet to the output register
	assign id_out.valid      = if_in.valid;
	assign id_out.pc         = if_in.pc;
	assign id_out.inst_class = inst_class;
	assign id_out.rd         = inst.r_fmt.rd;
	assign id_out.rs1        = inst.r_fmt.rs1;
	assign id_out.rs2        = inst.r_fmt.rs2;
	assign id_out.imm        = imm;

endmodule

//--- hdl/id_output_reg.sv
// decode output register
module id_output_reg import fetch_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  id_packet_t      id_in,
	output logic            out_valid,
	output logic [xlen-1:0] out_pc,
	output inst_class_t     out_class,
	output logic [4:0]      out_rd,
	output logic [4:0]      out_rs1,
	output logic [4:0]      out_rs2,
	output logic [xlen-1:0] out_imm
);

	////////////////////////////////////////////////////////////
	// valid flag
	////////////////////////////////////////////////////////////

	// trails the fetch valid by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= id_in.valid;
		end
	end

	////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////

	// loaded every cycle, only meaningful under out_valid
	always_ff @(posedge clock) begin
		out_pc    <= id_in.pc;
		out_class <= id_in.inst_class;
		out_rd    <= id_in.rd;
		out_rs1   <= id_in.rs1;
		out_rs2   <= id_in.rs2;
		out_imm   <= id_in.imm; // already sign extended
	end

endmodule

//--- hdl/fetch_top.sv
// fetch and decode front end
module fetch_top import fetch_pkg::*; #(
	parameter int imem_words = 256 // memory depth in 64-bit words
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          write_en,     // image load port
	input  logic [$clog2(imem_words)-1:0] write_addr,
	input  logic [63:0]                   write_data,
	input  logic                          fetch_enable,
	input  logic                          redirect,     // later stage redirect
	input  logic [xlen-1:0]               redirect_pc,
	output logic                          out_valid,
	output logic [xlen-1:0]               out_pc,
	output inst_class_t                   out_class,
	output logic [4:0]                    out_rd,
	output logic [4:0]                    out_rs1,
	output logic [4:0]                    out_rs2,
	output logic [xlen-1:0]               out_imm
);

	// memory bus
	logic [xlen-1:0] proc2imem_addr;
	bus_command_t    proc2imem_command;
	logic [63:0]     imem2proc_data;
	logic [3:0]      imem2proc_response;
	logic [3:0]      imem2proc_tag;

	// decode back to fetch
	logic            jal_take;
	logic [xlen-1:0] jal_target;

	id_packet_t id_pkt;

	fetch_if if_bus ();

	////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////

	imem_bank #(
		.imem_words (imem_words)
	) u_imem_bank (
		.clock              (clock),
		.reset              (reset),
		.write_en           (write_en),
		.write_addr         (write_addr),
		.write_data         (write_data),
		.proc2imem_addr     (proc2imem_addr),
		.proc2imem_command  (proc2imem_command),
		.imem2proc_data     (imem2proc_data),
		.imem2proc_response (imem2proc_response),
		.imem2proc_tag      (imem2proc_tag)
	);

	if_stage u_if_stage (
		.clock              (clock),
		.reset              (reset),
		.if_enable          (fetch_enable),
		.ex_take_branch     (redirect),
		.ex_target_pc       (redirect_pc),
		.jal_take           (jal_take),
		.jal_target         (jal_target),
		.imem2proc_data     (imem2proc_data),
		.imem2proc_response (imem2proc_response),
		.imem2proc_tag      (imem2proc_tag),
		.proc2imem_addr     (proc2imem_addr),
		.proc2imem_command  (proc2imem_command),
		.if_out             (if_bus.source)
	);

	inst_decode u_inst_decode (
		.if_in      (if_bus.sink),
		.id_out     (id_pkt),
		.jal_take   (jal_take),
		.jal_target (jal_target)
	);

	id_output_reg u_id_output_reg (
		.clock     (clock),
		.reset     (reset),
		.id_in     (id_pkt),
		.out_valid (out_valid),
		.out_pc    (out_pc),
		.out_class (out_class),
		.out_rd    (out_rd),
		.out_rs1   (out_rs1),
		.out_rs2   (out_rs2),
		.out_imm   (out_imm)
	);

endmodule

//--- test/tb_clock.sv
// testbench clock and reset
module tb_clock (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 10;

	// 40 ns period
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// power-on reset, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset <= 1'b0;
	end

endmodule

//--- test/tb_checker.sv
// fetch model and output compare
module tb_checker import fetch_pkg::*; #(
	parameter int imem_words = 256
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          write_en,
	input  logic [$clog2(imem_words)-1:0] write_addr,
	input  logic [63:0]                   write_data,
	input  logic                          fetch_enable,
	input  logic                          redirect,
	input  logic [31:0]                   redirect_pc,
	input  logic                          out_valid,
	input  logic [31:0]                   out_pc,
	input  inst_class_t                   out_class,
	input  logic [4:0]                    out_rd,
	input  logic [4:0]                    out_rs1,
	input  logic [4:0]                    out_rs2,
	input  logic [31:0]                   out_imm,
	output int                            error_count,
	output int                            valid_count
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int index_bits = $clog2(imem_words);

	// rv32 base opcodes
	localparam logic [6:0] opc_alu_reg = 7'h33;
	localparam logic [6:0] opc_alu_imm = 7'h13;
	localparam logic [6:0] opc_load    = 7'h03;
	localparam logic [6:0] opc_store   = 7'h23;
	localparam logic [6:0] opc_branch  = 7'h63;
	localparam logic [6:0] opc_jal     = 7'h6f;

	logic [63:0] shadow [imem_words]; // copy of the image, built from the write port
	logic [31:0] model_pc;            // pc the design should fetch next
	logic [31:0] fetch_word;
	logic        exp_valid;           // expected on the outputs now
	logic [31:0] exp_pc;
	logic [31:0] exp_word;

	////////////////////////////////////////////////////////////
	// decode rules
	////////////////////////////////////////////////////////////

	function automatic inst_class_t class_of(input logic [31:0] w);
		case (w[6:0])
			opc_alu_reg: return cls_alu_reg;
			opc_alu_imm: return cls_alu_imm;
			opc_load:    return cls_load;
			opc_store:   return cls_store;
			opc_branch:  return cls_branch;
			opc_jal:     return cls_jal;
			default:     return cls_other;
		endcase
	endfunction

	function automatic logic [31:0] imm_of(input logic [31:0] w);
		case (w[6:0])
			opc_alu_imm,
			opc_load:   return {{20{w[31]}}, w[31:20]};
			opc_store:  return {{20{w[31]}}, w[31:25], w[11:7]};
			opc_branch: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			opc_jal:    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:    return 32'h0; // no immediate
		endcase
	endfunction

	// a jal jumps by its offset, everything else falls through
	function automatic logic [31:0] step_pc(input logic [31:0] pc, input logic [31:0] w);
		if (w[6:0] == opc_jal) begin
			return pc + imm_of(w);
		end
		return pc + 32'd4;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("[FAIL] %s at pc %h: got %h expected %h", name, exp_pc, got, want);
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// pc walk
	////////////////////////////////////////////////////////////

	assign fetch_word = model_pc[2] ? shadow[model_pc[3 +: index_bits]][63:32]
	                                : shadow[model_pc[3 +: index_bits]][31:0];

	initial begin
		error_count = 0;
		valid_count = 0;
		exp_valid   = 1'b0;
	end

	always @(posedge clock) begin
		if (write_en) begin
			shadow[write_addr] <= write_data;
		end
		exp_valid <= !reset && fetch_enable; // one cycle latency
		exp_pc    <= model_pc;
		exp_word  <= fetch_word;
		if (reset) begin
			model_pc <= 32'h0;
		end else if (redirect) begin
			model_pc <= redirect_pc; // outside redirect beats everything
		end else if (fetch_enable) begin
			model_pc <= step_pc(model_pc, fetch_word);
		end
	end

	// outputs settle after the rising edge, compare in the low phase
	always @(negedge clock) begin
		if (exp_valid && out_valid !== 1'b1) begin
			$display("missing output: nothing came out for the fetch at pc %h", exp_pc);
			error_count++;
		end else if (!exp_valid && out_valid !== 1'b0) begin
			$display("unexpected output: out_valid rose with pc %h while nothing was fetched",
			         out_pc);
			error_count++;
		end else if (exp_valid) begin
			valid_count++;
			check_value("out_pc", out_pc, exp_pc);
			check_value("out_class", 32'(out_class), 32'(class_of(exp_word)));
			check_value("out_rd", 32'(out_rd), 32'(exp_word[11:7]));
			check_value("out_rs1", 32'(out_rs1), 32'(exp_word[19:15]));
			check_value("out_rs2", 32'(out_rs2), 32'(exp_word[24:20]));
			check_value("out_imm", out_imm, imm_of(exp_word));
		end
	end

endmodule

//--- test/tb_fetch_top.sv
// fetch front end testbench
module tb_fetch_top import fetch_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int imem_words = 256;
	localparam int index_bits = $clog2(imem_words);
	localparam int pat_depth  = 128;
	localparam int rec_fields = 6; // start, count, stall, target, redirect at, reset at

	logic                  clock;
	logic                  por_reset;
	logic                  run_reset; // mid-run reset
	logic                  reset;
	logic                  write_en;
	logic [index_bits-1:0] write_addr;
	logic [63:0]           write_data;
	logic                  fetch_enable;
	logic                  redirect;
	logic [31:0]           redirect_pc;
	logic                  out_valid;
	logic [31:0]           out_pc;
	inst_class_t           out_class;
	logic [4:0]            out_rd;
	logic [4:0]            out_rs1;
	logic [4:0]            out_rs2;
	logic [31:0]           out_imm;

	logic [63:0] pat [pat_depth]; // header, image, then test records
	int          image_words;
	int          test_count;
	int          rec_base;
	int          limit_cycles;
	int          tb_errors;
	int          monitor_errors;
	int          monitor_valids;
	int          t;

	assign reset = por_reset | run_reset;

	tb_clock clock_gen (
		.clock (clock),
		.reset (por_reset)
	);

	fetch_top #(
		.imem_words (imem_words)
	) dut (
		.clock        (clock),
		.reset        (reset),
		.write_en     (write_en),
		.write_addr   (write_addr),
		.write_data   (write_data),
		.fetch_enable (fetch_enable),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.out_valid    (out_valid),
		.out_pc       (out_pc),
		.out_class    (out_class),
		.out_rd       (out_rd),
		.out_rs1      (out_rs1),
		.out_rs2      (out_rs2),
		.out_imm      (out_imm)
	);

	tb_checker #(
		.imem_words (imem_words)
	) monitor (
		.clock        (clock),
		.reset        (reset),
		.write_en     (write_en),
		.write_addr   (write_addr),
		.write_data   (write_data),
		.fetch_enable (fetch_enable),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.out_valid    (out_valid),
		.out_pc       (out_pc),
		.out_class    (out_class),
		.out_rd       (out_rd),
		.out_rs1      (out_rs1),
		.out_rs2      (out_rs2),
		.out_imm      (out_imm),
		.error_count  (monitor_errors),
		.valid_count  (monitor_valids)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic int watchdog_cycles();
		int total;
		int i;
		total = 0;
		for (i = 0; i < test_count; i++) begin
			total += int'(pat[rec_base + rec_fields * i + 1][31:0]); // instruction counts
		end
		return total * 4 + 200;
	endfunction

	// image goes in while reset still holds
	task automatic load_image();
		int w;
		for (w = 0; w < image_words; w++) begin
			@(negedge clock);
			write_en   = 1'b1;
			write_addr = index_bits'(w);
			write_data = pat[2 + w];
		end
		@(negedge clock);
		write_en = 1'b0;
	endtask

	// fetch stays on so the reset has a live valid to clear
	task automatic pulse_reset();
		fetch_enable = 1'b1;
		redirect     = 1'b0;
		run_reset    = 1'b1;
		repeat (2) @(negedge clock);
		run_reset = 1'b0;
	endtask

	task automatic run_test(input int idx);
		int          rec;
		logic [31:0] start_pc;
		int          count;
		logic        stall;
		logic [31:0] target_pc;
		int          redirect_at;
		int          reset_at;
		int          fetched;
		int          errors_before;
		int          valids_before;
		int          outputs;
		logic        enable;
		rec         = rec_base + rec_fields * idx;
		start_pc    = pat[rec][31:0];
		count       = pat[rec + 1][31:0];
		stall       = pat[rec + 2][0];
		target_pc   = pat[rec + 3][31:0];
		redirect_at = pat[rec + 4][31:0]; // zero means none
		reset_at    = pat[rec + 5][31:0];
		errors_before = monitor_errors + tb_errors;
		valids_before = monitor_valids;
		@(negedge clock);
		fetch_enable = 1'b0;
		redirect     = 1'b1; // park the pc at the start
		redirect_pc  = start_pc;
		@(negedge clock);
		fetched = 0;
		while (fetched < count) begin
			enable = 1'b1;
			if (stall) begin
				enable = (($urandom % 3) != 0); // drop about one cycle in three
			end
			fetch_enable = enable;
			redirect     = 1'b0;
			if (enable) begin
				fetched++;
				if (fetched == redirect_at) begin
					redirect    = 1'b1; // same cycle as this fetch
					redirect_pc = target_pc;
				end
			end
			@(negedge clock);
			if (enable && fetched == reset_at) begin
				pulse_reset();
			end
		end
		fetch_enable = 1'b0;
		redirect     = 1'b0;
		@(negedge clock);
		@(posedge clock);
		outputs = monitor_valids - valids_before;
		if (outputs != count) begin
			$display("test %0d lost or repeated instructions: %0d outputs for %0d fetches",
			         idx + 1, outputs, count);
			tb_errors++;
		end
		$display("test %0d from pc %h: %0d outputs, %0d errors", idx + 1, start_pc, outputs,
		         monitor_errors + tb_errors - errors_before);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		write_en     = 1'b0;
		write_addr   = '0;
		write_data   = 64'h0;
		fetch_enable = 1'b0;
		redirect     = 1'b0;
		redirect_pc  = 32'h0;
		run_reset    = 1'b0;
		tb_errors    = 0;
		limit_cycles = 0;
		void'($urandom(32'h7c53da38)); // one seed for the whole run
		$readmemh("test/fetch_patterns.mem", pat);
		image_words  = pat[0][31:0];
		test_count   = pat[1][31:0];
		rec_base     = 2 + image_words;
		limit_cycles = watchdog_cycles();
		load_image();
		while (por_reset) begin
			@(negedge clock);
		end
		for (t = 0; t < test_count; t++) begin
			run_test(t);
		end
		$display("%0d tests, %0d outputs checked, %0d errors", test_count, monitor_valids,
		         monitor_errors + tb_errors);
		if (monitor_errors + tb_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clock);
		$display("run did not finish within %0d cycles", limit_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- test/fetch_patterns.mem
// word 0 image length in 64-bit words, word 1 number of tests, then the image
// (upper half is pc+4), then per test: start_pc count stall redirect_pc redirect_at reset_at
8
6
002081b3_00500093
00532623_ff812203
123453b7_fe2088e3
00148493_010000ef
fff44413_00250513
40e68633_fff58593
fed10fa3_00368693
00100073_ff9ff06f
// sequential fetch across both halves
00000000 6 0 00000000 0 0
// forward jal to 0x28
00000014 4 0 00000000 0 0
// backward jal loop, three turns
00000030 9 0 00000000 0 0
// random fetch_enable drops
00000000 c 1 00000000 0 0
// outside redirect on the jal cycle
00000030 5 0 00000008 3 0
// reset after the third fetch
00000028 6 0 00000000 0 3

//--- verilog.f
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/imem_bank.sv
hdl/if_stage.sv
hdl/inst_decode.sv
hdl/id_output_reg.sv
hdl/fetch_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_fetch_top.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= verilog.f
PATTERNS  ?= test/fetch_patterns.mem
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(BIN) $(PATTERNS)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(BUILD_DIR)
